// File: Makefile
TOP := tb_tree_engine
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q -F '** PASS **' sim.log

clean:
	rm -rf $(OBJ) sim.log

// File: logic/node_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "tree_config.svh"

module node_datapath (
    input  wire                          clk,
    input  wire                          arst_n,
    input  tree_pkg::load_t              load,
    input  tree_pkg::step_t              step,
    input  wire                          exec_en,
    input  wire  [`TREE_IDX_W-1:0]       rd_idx,
    output logic [`TREE_WORD_W-1:0]      rd_data
);

    localparam int NODES = 1 << `TREE_IDX_W;

    logic [`TREE_WORD_W-1:0] mem [NODES];
    logic [`TREE_WORD_W-1:0] sum;

    assign sum = mem[step.src_l] + mem[step.src_r]; // Modulo word width.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NODES; i++) begin
                mem[i] <= '0;
            end
        end else if (exec_en) begin
            mem[step.parent] <= sum;
        end else if (load.valid) begin
            mem[load.idx] <= load.data;
        end
    end

    assign rd_data = mem[rd_idx];

    // Top level masks host loads while a phase runs.
    a_load_exec_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(load.valid && exec_en))
        else $error("node_datapath: host load during step write");

endmodule

`default_nettype wire

// File: logic/sched_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sched_fsm (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  start,
    input  tree_pkg::phase_t     phase_in,
    input  wire                  last,
    output tree_pkg::phase_t     phase,
    output logic                 cnt_clr,
    output logic                 cnt_en,
    output logic                 exec_en,
    output logic                 busy,
    output logic                 done
);

    tree_pkg::fsm_state_t state;
    tree_pkg::fsm_state_t state_nx;
    logic                 start_acc;

    assign start_acc = (state == tree_pkg::IDLE) && start;

    always_comb begin
        state_nx = state;
        case (state)
            tree_pkg::IDLE: begin
                if (start) state_nx = tree_pkg::ISSUE;
            end
            tree_pkg::ISSUE: begin
                if (last) state_nx = tree_pkg::DRAIN;
            end
            tree_pkg::DRAIN: begin
                if (!exec_en) state_nx = tree_pkg::IDLE; // Final write has landed.
            end
            default: state_nx = tree_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= tree_pkg::IDLE;
            phase   <= '0;
            exec_en <= 1'b0;
            done    <= 1'b0;
        end else begin
            state   <= state_nx;
            exec_en <= (state == tree_pkg::ISSUE); // Lines up with ROM output.
            done    <= (state == tree_pkg::DRAIN) && !exec_en;
            if (start_acc) phase <= phase_in;
        end
    end

    assign cnt_clr = start_acc;
    assign cnt_en  = (state == tree_pkg::ISSUE);
    assign busy    = (state != tree_pkg::IDLE);

    // Host must not restart in the cycle that reports the previous run.
    a_no_done_at_start: assert property (@(posedge clk) disable iff (!arst_n)
        start_acc |-> !done)
        else $error("sched_fsm: start accepted while done is high");

endmodule

`default_nettype wire

// File: logic/step_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tree_config.svh"

module step_counter (
    input  wire                                   clk,
    input  wire                                   arst_n,
    input  wire                                   clr,
    input  wire                                   en,
    output logic [$clog2(`TREE_PHASE_LEN)-1:0]    offset,
    output logic                                  last
);

    localparam int OFF_W = $clog2(`TREE_PHASE_LEN);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            offset <= '0;
        end else if (clr) begin
            offset <= '0;
        end else if (en) begin
            offset <= offset + 1'b1; // Wraps to zero after the last step.
        end
    end

    assign last = (offset == OFF_W'(`TREE_PHASE_LEN - 1));

    // The FSM clears only from IDLE and counts only in ISSUE.
    a_clr_en_excl: assert property (@(posedge clk) disable iff (!arst_n) !(clr && en))
        else $error("step_counter: clr and en together");

endmodule

`default_nettype wire

// File: logic/step_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "tree_config.svh"

module step_rom (
    input  wire                      clk,
    input  wire [`TREE_STEP_AW-1:0]  addr,
    output tree_pkg::step_t          data
);

    // Packs one schedule entry as parent, left source and right source.
    function automatic tree_pkg::step_t trip(
        input int unsigned parent,
        input int unsigned src_l,
        input int unsigned src_r
    );
        return {src_r[`TREE_IDX_W-1:0], src_l[`TREE_IDX_W-1:0], parent[`TREE_IDX_W-1:0]};
    endfunction

    always_ff @(posedge clk) begin
        case (addr)
            // Phase 0, root from its two children.
            7'd0:    data <= trip(0, 1, 2);
            7'd1:    data <= trip(0, 1, 2);
            7'd2:    data <= trip(0, 1, 2);
            7'd3:    data <= trip(0, 1, 2);
            7'd4:    data <= trip(0, 1, 2);
            7'd5:    data <= trip(0, 1, 2);
            7'd6:    data <= trip(0, 1, 2);
            7'd7:    data <= trip(0, 1, 2);
            7'd8:    data <= trip(0, 1, 2);
            7'd9:    data <= trip(0, 1, 2);
            7'd10:   data <= trip(0, 1, 2);
            7'd11:   data <= trip(0, 1, 2);
            7'd12:   data <= trip(0, 1, 2);
            7'd13:   data <= trip(0, 1, 2);
            7'd14:   data <= trip(0, 1, 2);
            7'd15:   data <= trip(0, 1, 2);
            7'd16:   data <= trip(0, 1, 2);
            7'd17:   data <= trip(0, 1, 2);
            7'd18:   data <= trip(0, 1, 2);
            7'd19:   data <= trip(0, 1, 2);
            7'd20:   data <= trip(0, 1, 2);
            7'd21:   data <= trip(0, 1, 2);
            7'd22:   data <= trip(0, 1, 2);
            7'd23:   data <= trip(0, 1, 2);
            7'd24:   data <= trip(0, 1, 2);
            7'd25:   data <= trip(0, 1, 2);
            7'd26:   data <= trip(0, 1, 2);
            7'd27:   data <= trip(0, 1, 2);
            7'd28:   data <= trip(0, 1, 2);
            7'd29:   data <= trip(0, 1, 2);
            7'd30:   data <= trip(0, 1, 2);
            7'd31:   data <= trip(0, 1, 2);
            // Phase 1, nodes 3 to 6, eight steps each.
            7'd32:   data <= trip(3, 7, 8);
            7'd33:   data <= trip(3, 7, 8);
            7'd34:   data <= trip(3, 7, 8);
            7'd35:   data <= trip(3, 7, 8);
            7'd36:   data <= trip(3, 7, 8);
            7'd37:   data <= trip(3, 7, 8);
            7'd38:   data <= trip(3, 7, 8);
            7'd39:   data <= trip(3, 7, 8);
            7'd40:   data <= trip(4, 9, 10);
            7'd41:   data <= trip(4, 9, 10);
            7'd42:   data <= trip(4, 9, 10);
            7'd43:   data <= trip(4, 9, 10);
            7'd44:   data <= trip(4, 9, 10);
            7'd45:   data <= trip(4, 9, 10);
            7'd46:   data <= trip(4, 9, 10);
            7'd47:   data <= trip(4, 9, 10);
            7'd48:   data <= trip(5, 11, 12);
            7'd49:   data <= trip(5, 11, 12);
            7'd50:   data <= trip(5, 11, 12);
            7'd51:   data <= trip(5, 11, 12);
            7'd52:   data <= trip(5, 11, 12);
            7'd53:   data <= trip(5, 11, 12);
            7'd54:   data <= trip(5, 11, 12);
            7'd55:   data <= trip(5, 11, 12);
            7'd56:   data <= trip(6, 13, 14);
            7'd57:   data <= trip(6, 13, 14);
            7'd58:   data <= trip(6, 13, 14);
            7'd59:   data <= trip(6, 13, 14);
            7'd60:   data <= trip(6, 13, 14);
            7'd61:   data <= trip(6, 13, 14);
            7'd62:   data <= trip(6, 13, 14);
            7'd63:   data <= trip(6, 13, 14);
            // Phase 2, nodes 15 to 30, two steps each.
            7'd64:   data <= trip(15, 31, 32);
            7'd65:   data <= trip(15, 31, 32);
            7'd66:   data <= trip(16, 33, 34);
            7'd67:   data <= trip(16, 33, 34);
            7'd68:   data <= trip(17, 35, 36);
            7'd69:   data <= trip(17, 35, 36);
            7'd70:   data <= trip(18, 37, 38);
            7'd71:   data <= trip(18, 37, 38);
            7'd72:   data <= trip(19, 39, 40);
            7'd73:   data <= trip(19, 39, 40);
            7'd74:   data <= trip(20, 41, 42);
            7'd75:   data <= trip(20, 41, 42);
            7'd76:   data <= trip(21, 43, 44);
            7'd77:   data <= trip(21, 43, 44);
            7'd78:   data <= trip(22, 45, 46);
            7'd79:   data <= trip(22, 45, 46);
            7'd80:   data <= trip(23, 47, 48);
            7'd81:   data <= trip(23, 47, 48);
            7'd82:   data <= trip(24, 49, 50);
            7'd83:   data <= trip(24, 49, 50);
            7'd84:   data <= trip(25, 51, 52);
            7'd85:   data <= trip(25, 51, 52);
            7'd86:   data <= trip(26, 53, 54);
            7'd87:   data <= trip(26, 53, 54);
            7'd88:   data <= trip(27, 55, 56);
            7'd89:   data <= trip(27, 55, 56);
            7'd90:   data <= trip(28, 57, 58);
            7'd91:   data <= trip(28, 57, 58);
            7'd92:   data <= trip(29, 59, 60);
            7'd93:   data <= trip(29, 59, 60);
            7'd94:   data <= trip(30, 61, 62);
            7'd95:   data <= trip(30, 61, 62);
            // Phase 3, root from pairs four apart; last step wins.
            7'd96:   data <= trip(0, 4, 0);
            7'd97:   data <= trip(0, 5, 1);
            7'd98:   data <= trip(0, 6, 2);
            7'd99:   data <= trip(0, 7, 3);
            7'd100:  data <= trip(0, 12, 8);
            7'd101:  data <= trip(0, 13, 9);
            7'd102:  data <= trip(0, 14, 10);
            7'd103:  data <= trip(0, 15, 11);
            7'd104:  data <= trip(0, 20, 16);
            7'd105:  data <= trip(0, 21, 17);
            7'd106:  data <= trip(0, 22, 18);
            7'd107:  data <= trip(0, 23, 19);
            7'd108:  data <= trip(0, 28, 24);
            7'd109:  data <= trip(0, 29, 25);
            7'd110:  data <= trip(0, 30, 26);
            7'd111:  data <= trip(0, 31, 27);
            7'd112:  data <= trip(0, 36, 32);
            7'd113:  data <= trip(0, 37, 33);
            7'd114:  data <= trip(0, 38, 34);
            7'd115:  data <= trip(0, 39, 35);
            7'd116:  data <= trip(0, 44, 40);
            7'd117:  data <= trip(0, 45, 41);
            7'd118:  data <= trip(0, 46, 42);
            7'd119:  data <= trip(0, 47, 43);
            7'd120:  data <= trip(0, 52, 48);
            7'd121:  data <= trip(0, 53, 49);
            7'd122:  data <= trip(0, 54, 50);
            7'd123:  data <= trip(0, 55, 51);
            7'd124:  data <= trip(0, 60, 56);
            7'd125:  data <= trip(0, 61, 57);
            7'd126:  data <= trip(0, 62, 58);
            7'd127:  data <= trip(0, 63, 59);
            default: data <= '0;
        endcase
    end

    a_addr_known: assert property (@(posedge clk) !$isunknown(addr))
        else $error("step_rom: unknown address");

endmodule

`default_nettype wire

// File: logic/tree_config.svh
`ifndef TREE_CONFIG_SVH
`define TREE_CONFIG_SVH

// Node store word width in bits.
`define TREE_WORD_W 16

// Node index width, enough for a 64-node heap.
`define TREE_IDX_W 6

// Schedule ROM address width, 4 phases of 32 steps.
`define TREE_STEP_AW 7

// Steps per phase.
`define TREE_PHASE_LEN 32

`endif

// File: logic/tree_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tree_config.svh"

module tree_engine_top (
    input  wire                          clk,
    input  wire                          arst_n,
    input  tree_pkg::load_t              load,
    input  wire                          start,
    input  tree_pkg::phase_t             phase,
    input  wire  [`TREE_IDX_W-1:0]       rd_idx,
    output logic [`TREE_WORD_W-1:0]      rd_data,
    output logic                         busy,
    output logic                         done
);

    tree_pkg::phase_t                       phase_q;
    tree_pkg::step_t                        step;
    tree_pkg::load_t                        load_gated;
    logic                                   cnt_clr;
    logic                                   cnt_en;
    logic                                   exec_en;
    logic                                   last;
    logic [$clog2(`TREE_PHASE_LEN)-1:0]     offset;
    logic [`TREE_STEP_AW-1:0]               rom_addr;

    assign rom_addr = {phase_q, offset}; // Phase selects a 32-step block.

    always_comb begin
        load_gated       = load;
        load_gated.valid = load.valid && !busy; // Host writes wait for idle.
    end

    sched_fsm u_fsm (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .phase_in (phase),
        .last     (last),
        .phase    (phase_q),
        .cnt_clr  (cnt_clr),
        .cnt_en   (cnt_en),
        .exec_en  (exec_en),
        .busy     (busy),
        .done     (done)
    );

    step_counter u_cnt (
        .clk    (clk),
        .arst_n (arst_n),
        .clr    (cnt_clr),
        .en     (cnt_en),
        .offset (offset),
        .last   (last)
    );

    step_rom u_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (step)
    );

    node_datapath u_dp (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (load_gated),
        .step    (step),
        .exec_en (exec_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: logic/tree_pkg.sv
`default_nettype none

`include "tree_config.svh"

package tree_pkg;

    // Field order matches the ROM word, high to low.
    typedef struct packed {
        logic [`TREE_IDX_W-1:0] src_r;  // Right source node.
        logic [`TREE_IDX_W-1:0] src_l;  // Left source node.
        logic [`TREE_IDX_W-1:0] parent; // Destination node.
    } step_t;

    typedef struct packed {
        logic                    valid;
        logic [`TREE_IDX_W-1:0]  idx;
        logic [`TREE_WORD_W-1:0] data;
    } load_t;

    typedef logic [1:0] phase_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2
    } fsm_state_t;

endpackage

`default_nettype wire

// File: sim/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "tree_config.svh"

module tb_checker (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      busy,
    input  wire                      done,
    input  wire [`TREE_IDX_W-1:0]    rd_idx,
    input  wire [`TREE_WORD_W-1:0]   rd_data,
    input  wire [`TREE_WORD_W-1:0]   exp_data,
    input  wire                      cmp,
    input  wire                      final_chk,
    input  int                       starts_sent,
    output int                       value_errs,
    output int                       timing_errs
);

    localparam int DONE_LAT = 34; // Accepted start to done, in cycles.

    int   busy_run;
    int   done_cnt;
    logic busy_q;
    logic done_q;
    logic fresh;

    initial begin
        value_errs  = 0;
        timing_errs = 0;
        busy_run    = 0;
        done_cnt    = 0;
        busy_q      = 1'b0;
        done_q      = 1'b0;
        fresh       = 1'b1;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            if (fresh && (busy || done)) begin
                timing_errs++;
                $display("FAIL %0t: busy or done high right after reset", $time);
            end
            fresh = 1'b0;
            if (cmp && rd_data !== exp_data) begin
                value_errs++;
                $display("FAIL %0t: node %0d reads %h, expected %h",
                         $time, rd_idx, rd_data, exp_data);
            end
            if (done) begin
                done_cnt++;
                if (done_q) begin
                    timing_errs++;
                    $display("FAIL %0t: done high for more than one cycle", $time);
                end else if (!busy_q || busy || busy_run != DONE_LAT) begin
                    timing_errs++;
                    $display("FAIL %0t: done after %0d busy cycles, expected %0d",
                             $time, busy_run, DONE_LAT);
                end
            end else if (busy_q && !busy) begin
                timing_errs++;
                $display("FAIL %0t: busy dropped without a done pulse", $time);
            end
            if (final_chk && done_cnt != starts_sent) begin
                timing_errs++;
                $display("FAIL %0t: %0d done pulses for %0d accepted starts",
                         $time, done_cnt, starts_sent);
            end
            busy_run = busy ? busy_run + 1 : 0;
            busy_q   = busy;
            done_q   = done;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1; // Released just after an edge, like the other inputs.
    end

endmodule

`default_nettype wire

// File: sim/tb_tree_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "tree_config.svh"

module tb_tree_engine;

    localparam int                      CYCLE_NS      = 40;
    localparam int                      DONE_WAIT     = 100;   // Cycles before done counts as lost.
    localparam logic [`TREE_IDX_W-1:0]  BUSY_LOAD_IDX = 6'd40; // Feeds node 19 in phase 2.
    localparam logic [`TREE_WORD_W-1:0] BUSY_LOAD_VAL = 16'hdead;
    localparam string                   INPUT_FILE    = "sim/tree_input.txt";

    logic                    clk;
    logic                    arst_n;
    tree_pkg::load_t         load;
    logic                    start;
    tree_pkg::phase_t        phase;
    logic [`TREE_IDX_W-1:0]  rd_idx;
    logic [`TREE_WORD_W-1:0] rd_data;
    logic                    busy;
    logic                    done;

    logic [`TREE_WORD_W-1:0] exp_data;
    logic                    cmp;
    logic                    final_chk;
    logic                    cmds_ready;
    int                      starts_sent;
    int                      value_errs;
    int                      timing_errs;
    int                      other_errs;

    logic [7:0]              cmd_op [$];
    int                      cmd_a  [$];
    int                      cmd_b  [$];

    tb_clock #(.PERIOD_NS(CYCLE_NS), .RST_CYCLES(5)) u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tree_engine_top DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (load),
        .start   (start),
        .phase   (phase),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done)
    );

    tb_checker u_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .busy        (busy),
        .done        (done),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .exp_data    (exp_data),
        .cmp         (cmp),
        .final_chk   (final_chk),
        .starts_sent (starts_sent),
        .value_errs  (value_errs),
        .timing_errs (timing_errs)
    );

    task automatic read_commands();
        int         fd;
        int         n;
        int         a;
        int         b;
        string      line;
        logic [7:0] op;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the command file %s", INPUT_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1) begin
                    op = line.getc(0);
                    if (op == "L" || op == "S" || op == "R") begin // Other lines are comments.
                        a = 0;
                        b = 0;
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                        cmd_op.push_back(op);
                        cmd_a.push_back(a);
                        cmd_b.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_node(input int idx, input int value);
        @(posedge clk);
        #1;
        load.valid = 1'b1;
        load.idx   = idx[`TREE_IDX_W-1:0];
        load.data  = value[`TREE_WORD_W-1:0];
        @(posedge clk);
        #1;
        load.valid = 1'b0;
    endtask

    task automatic read_node(input int idx, input int value);
        @(posedge clk);
        #1;
        rd_idx   = idx[`TREE_IDX_W-1:0];
        exp_data = value[`TREE_WORD_W-1:0];
        cmp      = 1'b1;
        @(posedge clk);
        #1;
        cmp      = 1'b0;
    endtask

    task automatic run_phase(input int ph);
        int waited;
        @(posedge clk);
        #1;
        start = 1'b1;
        phase = ph[1:0];
        starts_sent++;
        @(posedge clk);
        #1;
        start      = 1'b1;        // Second start and a host write in the first busy cycle.
        phase      = ~ph[1:0];
        load.valid = 1'b1;        // No step write lands on this edge.
        load.idx   = BUSY_LOAD_IDX;
        load.data  = BUSY_LOAD_VAL;
        @(posedge clk);
        #1;
        start      = 1'b0;
        load.valid = 1'b0;
        waited     = 0;
        while (!done && waited < DONE_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done) begin
            other_errs++;
            $display("no done pulse within %0d cycles of starting phase %0d", DONE_WAIT, ph);
        end
    endtask

    // Watchdog sized from the command count.
    initial begin
        int wd_cycles;
        wait (cmds_ready);
        wd_cycles = 40 * cmd_op.size() + 200;
        #(wd_cycles * CYCLE_NS);
        $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int total;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h8b07));
        load        = '0;
        start       = 1'b0;
        phase       = '0;
        rd_idx      = '0;
        exp_data    = '0;
        cmp         = 1'b0;
        final_chk   = 1'b0;
        cmds_ready  = 1'b0;
        starts_sent = 0;
        other_errs  = 0;
        read_commands();
        cmds_ready = 1'b1;
        wait (arst_n === 1'b1);
        for (int i = 0; i < (1 << `TREE_IDX_W); i++) begin
            read_node(i, 0); // Store resets to zero.
        end
        for (int i = 0; i < cmd_op.size(); i++) begin
            repeat ($urandom % 4) @(posedge clk);
            case (cmd_op[i])
                "L":     write_node(cmd_a[i], cmd_b[i]);
                "S":     run_phase(cmd_a[i]);
                default: read_node(cmd_a[i], cmd_b[i]);
            endcase
        end
        @(posedge clk);
        #1;
        final_chk = 1'b1;
        @(posedge clk);
        #1;
        final_chk = 1'b0;
        total = value_errs + timing_errs + other_errs;
        $display("errors: value %0d, timing %0d, other %0d", value_errs, timing_errs, other_errs);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tree_input.txt
# L idx value: load node idx. R idx value: read node idx, expect value. S ph: run phase ph.
# All numbers are hex; node 0 gets node 1 plus node 2 in phase 0, and so on.
L 01 1234
L 02 f00d
R 01 1234
R 02 f00d
S 0
R 00 0241
R 02 f00d
L 07 0100
L 08 0023
L 09 8000
L 0a 8001
L 0b ffff
L 0c 0005
L 0d 0abc
S 1
R 03 0123
R 04 0001
R 05 0004
R 06 0abc
R 00 0241
L 1f c000
L 20 4321
L 3d 0005
L 3e 0007
S 2
R 0f 0321
R 1e 000c
R 13 0000
L 3b 7777
L 3f 9999
S 3
R 00 1110
R 28 0000
R 3b 7777

// File: vlog.f
+incdir+logic
logic/tree_pkg.sv
logic/step_rom.sv
logic/step_counter.sv
logic/sched_fsm.sv
logic/node_datapath.sv
logic/tree_engine_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_tree_engine.sv
